// ==== hdl/i3c_bus_pkg.sv ====
package i3c_bus_pkg;

   // *********************************************************************
   // Bus events reported to the consumer
   // *********************************************************************

   // The code value is also the bit index into the event mask
   typedef enum logic [1:0]
   {
      EVT_START       = 2'd0,
      EVT_STOP        = 2'd1,
      EVT_HDR_EXIT    = 2'd2,
      EVT_HDR_RESTART = 2'd3
   } evt_code_t;

   localparam int STAMP_WIDTH = 16;  // Cycle timestamp attached to each event

   // *********************************************************************
   // HDR exit and restart pattern
   // *********************************************************************

   // SDA falls counted while SCL is held low before the closing STOP or START
   localparam int HDR_EXIT_FALLS = 4;

   localparam int HDR_FALL_CNT_W = $clog2(HDR_EXIT_FALLS + 1);

endpackage

// ==== hdl/monitor_cfg_pkg.sv ====
package monitor_cfg_pkg;

   // *********************************************************************
   // Register map
   // *********************************************************************

   localparam logic [2:0] REG_CTRL     = 3'd0;
   localparam logic [2:0] REG_FILTER   = 3'd1;
   localparam logic [2:0] REG_EVT_MASK = 3'd2;
   localparam logic [2:0] REG_DROP_CNT = 3'd3;

   // Bit positions inside CTRL
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_HDR_BIT    = 1;

   localparam int DROP_CNT_W = 8;  // Saturates at all ones

   // *********************************************************************
   // Configuration seen by the detection logic
   // *********************************************************************

   typedef struct packed
   {
      logic       enable;
      logic       hdr_active;    // Set by software, cleared on HDR exit
      logic [2:0] filter_depth;  // Extra stable cycles before a line change is accepted
      logic [3:0] evt_mask;      // One enable bit per event code
   } cfg_t;

endpackage

// ==== hdl/bus_line_if.sv ====
interface bus_line_if;

   // Filtered line levels
   logic scl;
   logic sda;

   // One cycle strobes, high in the cycle the filtered level has just changed
   logic scl_rise;
   logic scl_fall;
   logic sda_rise;
   logic sda_fall;

   modport source
   (
      output scl, sda, scl_rise, scl_fall, sda_rise, sda_fall
   );

   modport sink
   (
      input scl, sda, scl_rise, scl_fall, sda_rise, sda_fall
   );

endinterface

// ==== hdl/bus_sampler.sv ====
module bus_sampler
(
   input  logic                  i_sys_clk,
   input  logic                  i_sys_rst,
   input  logic                  i_scl,
   input  logic                  i_sda,
   input  monitor_cfg_pkg::cfg_t i_cfg,
   bus_line_if.source            o_line
);

   // Bit 0 is SCL and bit 1 is SDA in every vector below
   logic [1:0]      meta_q;
   logic [1:0]      sync_q;
   logic [1:0]      filt_q;
   logic [1:0]      rise_q;
   logic [1:0]      fall_q;
   logic [1:0][2:0] stable_cnt_q;

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
      begin
         meta_q       <= 2'b11;  // Idle bus reads high on both lines
         sync_q       <= 2'b11;
         filt_q       <= 2'b11;
         rise_q       <= '0;
         fall_q       <= '0;
         stable_cnt_q <= '0;
      end
      else
      begin
         meta_q <= {i_sda, i_scl};
         sync_q <= meta_q;
         for (int i = 0; i < 2; i++)
         begin
            rise_q[i] <= 1'b0;
            fall_q[i] <= 1'b0;
            if (!i_cfg.enable)
            begin
               filt_q[i]       <= sync_q[i];  // Track the pins quietly
               stable_cnt_q[i] <= '0;
            end
            else if (sync_q[i] == filt_q[i])
               stable_cnt_q[i] <= '0;  // Glitch gone, start over
            else if (stable_cnt_q[i] >= i_cfg.filter_depth)
            begin
               filt_q[i]       <= sync_q[i];
               rise_q[i]       <= sync_q[i];
               fall_q[i]       <= !sync_q[i];
               stable_cnt_q[i] <= '0;
            end
            else
               stable_cnt_q[i] <= stable_cnt_q[i] + 3'd1;
         end
      end
   end

   assign o_line.scl      = filt_q[0];
   assign o_line.sda      = filt_q[1];
   assign o_line.scl_rise = rise_q[0];
   assign o_line.scl_fall = fall_q[0];
   assign o_line.sda_rise = rise_q[1];
   assign o_line.sda_fall = fall_q[1];

endmodule

// ==== hdl/bus_condition_detector.sv ====
module bus_condition_detector
(
   input  logic                  i_sys_clk,
   input  logic                  i_sys_rst,
   bus_line_if.sink              i_line,
   input  monitor_cfg_pkg::cfg_t i_cfg,
   output logic                  o_start,
   output logic                  o_stop
);

   logic scl_steady_high;
   logic start_seen;
   logic stop_seen;

   // SCL must already be high, not rising in the same cycle as the SDA edge
   assign scl_steady_high = i_line.scl && !i_line.scl_rise;

   // A repeated START looks the same on the wires and gets the same code
   assign start_seen = i_line.sda_fall && scl_steady_high;
   assign stop_seen  = i_line.sda_rise && scl_steady_high;

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
      begin
         o_start <= 1'b0;
         o_stop  <= 1'b0;
      end
      else
      begin
         o_start <= i_cfg.enable && start_seen;
         o_stop  <= i_cfg.enable && stop_seen;
      end
   end

endmodule

// ==== hdl/hdr_exit_detector.sv ====
module hdr_exit_detector
(
   input  logic                  i_sys_clk,
   input  logic                  i_sys_rst,
   bus_line_if.sink              i_line,
   input  monitor_cfg_pkg::cfg_t i_cfg,
   input  logic                  i_start,
   input  logic                  i_stop,
   output logic                  o_hdr_exit,
   output logic                  o_hdr_restart
);

   import i3c_bus_pkg::*;

   typedef enum logic [1:0]
   {
      S_COUNT,     // Counting SDA falls under a low SCL
      S_ARMED,     // Pattern seen, waiting for SCL to go high
      S_SCL_HIGH   // SCL high, the next SDA edge decides exit or restart
   } state_t;

   state_t                    state_q;
   logic [HDR_FALL_CNT_W-1:0] fall_cnt_q;
   logic                      hdr_watch;
   logic                      low_fall;

   assign hdr_watch = i_cfg.enable && i_cfg.hdr_active;
   assign low_fall  = i_line.sda_fall && !i_line.scl;

   // *********************************************************************
   // Exit pattern FSM
   // *********************************************************************

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
      begin
         state_q       <= S_COUNT;
         fall_cnt_q    <= '0;
         o_hdr_exit    <= 1'b0;
         o_hdr_restart <= 1'b0;
      end
      else
      begin
         o_hdr_exit    <= 1'b0;
         o_hdr_restart <= 1'b0;
         if (!hdr_watch)
         begin
            state_q    <= S_COUNT;
            fall_cnt_q <= '0;
         end
         else
         begin
            case (state_q)
               S_COUNT:
               begin
                  if (i_line.scl_rise)
                     fall_cnt_q <= '0;  // Normal HDR clocking, not an exit
                  else if (low_fall)
                  begin
                     if (fall_cnt_q == HDR_FALL_CNT_W'(HDR_EXIT_FALLS - 1))
                     begin
                        fall_cnt_q <= '0;
                        state_q    <= S_ARMED;
                     end
                     else
                        fall_cnt_q <= fall_cnt_q + 1'b1;
                  end
               end

               S_ARMED:
               begin
                  if (i_line.scl_rise)
                     state_q <= S_SCL_HIGH;
               end

               S_SCL_HIGH:
               begin
                  if (i_stop)
                  begin
                     o_hdr_exit <= 1'b1;
                     state_q    <= S_COUNT;
                  end
                  else if (i_start)
                  begin
                     o_hdr_restart <= 1'b1;
                     state_q       <= S_COUNT;
                  end
                  // An SCL pulse without STOP or START drops the pattern
                  else if (i_line.scl_fall)
                     state_q <= S_COUNT;
               end

               default:
                  state_q <= S_COUNT;
            endcase
         end
      end
   end

endmodule

// ==== hdl/event_credit_tx.sv ====
module event_credit_tx
#(
   parameter int EVENT_DEPTH = 8
)
(
   input  logic                                i_sys_clk,
   input  logic                                i_sys_rst,
   input  monitor_cfg_pkg::cfg_t               i_cfg,
   input  logic                                i_start,
   input  logic                                i_stop,
   input  logic                                i_hdr_exit,
   input  logic                                i_hdr_restart,
   input  logic                                i_evt_credit,
   output logic                                o_evt_valid,
   output i3c_bus_pkg::evt_code_t              o_evt_code,
   output logic [i3c_bus_pkg::STAMP_WIDTH-1:0] o_evt_stamp,
   output logic                                o_drop
);

   import i3c_bus_pkg::*;

   localparam int PTR_W    = $clog2(EVENT_DEPTH);
   localparam int CREDIT_W = 8;

   logic [STAMP_WIDTH-1:0] stamp_q;
   evt_code_t              mem_code  [EVENT_DEPTH];
   logic [STAMP_WIDTH-1:0] mem_stamp [EVENT_DEPTH];
   logic [PTR_W:0]         wr_ptr_q;
   logic [PTR_W:0]         rd_ptr_q;
   logic [CREDIT_W-1:0]    credit_q;
   logic                   start_q;  // START and STOP wait one cycle for a possible HDR pulse
   logic                   stop_q;
   evt_code_t              sel_code;
   logic                   sel_valid;
   logic                   push;
   logic                   full;
   logic                   empty;
   logic                   send;

   // HDR events win over the START or STOP that completed them
   always_comb
   begin
      sel_valid = 1'b1;
      if (i_hdr_exit)
         sel_code = EVT_HDR_EXIT;
      else if (i_hdr_restart)
         sel_code = EVT_HDR_RESTART;
      else if (stop_q)
         sel_code = EVT_STOP;
      else if (start_q)
         sel_code = EVT_START;
      else
      begin
         sel_code  = EVT_START;
         sel_valid = 1'b0;
      end
   end

   assign push  = sel_valid && i_cfg.evt_mask[sel_code];
   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                  (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
   assign send  = !empty && (credit_q != '0);

   // *********************************************************************
   // Pointers, credits and timestamp
   // *********************************************************************

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
      begin
         stamp_q     <= '0;
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         credit_q    <= '0;
         start_q     <= 1'b0;
         stop_q      <= 1'b0;
         o_evt_valid <= 1'b0;
         o_drop      <= 1'b0;
      end
      else
      begin
         stamp_q     <= stamp_q + 1'b1;
         start_q     <= i_start;
         stop_q      <= i_stop;
         o_evt_valid <= send;
         o_drop      <= push && full;
         if (push && !full)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (send)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (i_evt_credit && !send && credit_q != '1)
            credit_q <= credit_q + 1'b1;
         else if (!i_evt_credit && send)
            credit_q <= credit_q - 1'b1;
      end
   end

   // Queue storage and the output payload
   always_ff @(posedge i_sys_clk)
   begin
      if (push && !full)
      begin
         mem_code[wr_ptr_q[PTR_W-1:0]]  <= sel_code;
         mem_stamp[wr_ptr_q[PTR_W-1:0]] <= stamp_q;
      end
      if (send)
      begin
         o_evt_code  <= mem_code[rd_ptr_q[PTR_W-1:0]];
         o_evt_stamp <= mem_stamp[rd_ptr_q[PTR_W-1:0]];
      end
   end

endmodule

// ==== hdl/monitor_regs.sv ====
module monitor_regs
(
   input  logic                  i_sys_clk,
   input  logic                  i_sys_rst,
   input  logic                  i_reg_wr,
   input  logic                  i_reg_rd,
   input  logic [2:0]            i_reg_addr,
   input  logic [7:0]            i_reg_wdata,
   output logic [7:0]            o_reg_rdata,
   input  logic                  i_hdr_exit,
   input  logic                  i_drop,
   output monitor_cfg_pkg::cfg_t o_cfg
);

   import monitor_cfg_pkg::*;

   cfg_t                  cfg_q;
   logic [DROP_CNT_W-1:0] drop_cnt_q;
   logic [7:0]            rd_mux;

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
         cfg_q <= '0;
      else
      begin
         if (i_reg_wr && i_reg_addr == REG_CTRL)
         begin
            cfg_q.enable     <= i_reg_wdata[CTRL_ENABLE_BIT];
            cfg_q.hdr_active <= i_reg_wdata[CTRL_HDR_BIT];
         end
         if (i_hdr_exit)
            cfg_q.hdr_active <= 1'b0;  // The bus has left HDR, so this beats a write
         if (i_reg_wr && i_reg_addr == REG_FILTER)
            cfg_q.filter_depth <= i_reg_wdata[2:0];
         if (i_reg_wr && i_reg_addr == REG_EVT_MASK)
            cfg_q.evt_mask <= i_reg_wdata[3:0];
      end
   end

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
         drop_cnt_q <= '0;
      else if (i_reg_wr && i_reg_addr == REG_DROP_CNT)
         drop_cnt_q <= '0;  // Any write clears
      else if (i_drop && drop_cnt_q != '1)
         drop_cnt_q <= drop_cnt_q + 1'b1;
   end

   always_comb
   begin
      rd_mux = '0;
      case (i_reg_addr)
         REG_CTRL:
         begin
            rd_mux[CTRL_ENABLE_BIT] = cfg_q.enable;
            rd_mux[CTRL_HDR_BIT]    = cfg_q.hdr_active;
         end
         REG_FILTER:   rd_mux[2:0] = cfg_q.filter_depth;
         REG_EVT_MASK: rd_mux[3:0] = cfg_q.evt_mask;
         REG_DROP_CNT: rd_mux      = drop_cnt_q;
         default:      rd_mux      = '0;
      endcase
   end

   always_ff @(posedge i_sys_clk or negedge i_sys_rst)
   begin
      if (!i_sys_rst)
         o_reg_rdata <= '0;
      else if (i_reg_rd)
         o_reg_rdata <= rd_mux;
   end

   assign o_cfg = cfg_q;

endmodule

// ==== hdl/i3c_bus_monitor_top.sv ====
module i3c_bus_monitor_top
#(
   parameter int EVENT_DEPTH = 8
)
(
   input  logic                                i_sys_clk,
   input  logic                                i_sys_rst,
   input  logic                                i_scl,
   input  logic                                i_sda,
   input  logic                                i_reg_wr,
   input  logic                                i_reg_rd,
   input  logic [2:0]                          i_reg_addr,
   input  logic [7:0]                          i_reg_wdata,
   output logic [7:0]                          o_reg_rdata,
   input  logic                                i_evt_credit,
   output logic                                o_evt_valid,
   output i3c_bus_pkg::evt_code_t              o_evt_code,
   output logic [i3c_bus_pkg::STAMP_WIDTH-1:0] o_evt_stamp,
   output logic                                o_hdr_active
);

   import monitor_cfg_pkg::*;

   cfg_t cfg;
   logic start;
   logic stop;
   logic hdr_exit;
   logic hdr_restart;
   logic drop;

   bus_line_if line_bus ();

   bus_sampler u_sampler
   (
      .i_sys_clk (i_sys_clk),
      .i_sys_rst (i_sys_rst),
      .i_scl     (i_scl),
      .i_sda     (i_sda),
      .i_cfg     (cfg),
      .o_line    (line_bus)
   );

   bus_condition_detector u_cond
   (
      .i_sys_clk (i_sys_clk),
      .i_sys_rst (i_sys_rst),
      .i_line    (line_bus),
      .i_cfg     (cfg),
      .o_start   (start),
      .o_stop    (stop)
   );

   hdr_exit_detector u_hdr_exit
   (
      .i_sys_clk     (i_sys_clk),
      .i_sys_rst     (i_sys_rst),
      .i_line        (line_bus),
      .i_cfg         (cfg),
      .i_start       (start),
      .i_stop        (stop),
      .o_hdr_exit    (hdr_exit),
      .o_hdr_restart (hdr_restart)
   );

   event_credit_tx #(.EVENT_DEPTH(EVENT_DEPTH)) u_evt_tx
   (
      .i_sys_clk     (i_sys_clk),
      .i_sys_rst     (i_sys_rst),
      .i_cfg         (cfg),
      .i_start       (start),
      .i_stop        (stop),
      .i_hdr_exit    (hdr_exit),
      .i_hdr_restart (hdr_restart),
      .i_evt_credit  (i_evt_credit),
      .o_evt_valid   (o_evt_valid),
      .o_evt_code    (o_evt_code),
      .o_evt_stamp   (o_evt_stamp),
      .o_drop        (drop)
   );

   monitor_regs u_regs
   (
      .i_sys_clk   (i_sys_clk),
      .i_sys_rst   (i_sys_rst),
      .i_reg_wr    (i_reg_wr),
      .i_reg_rd    (i_reg_rd),
      .i_reg_addr  (i_reg_addr),
      .i_reg_wdata (i_reg_wdata),
      .o_reg_rdata (o_reg_rdata),
      .i_hdr_exit  (hdr_exit),
      .i_drop      (drop),
      .o_cfg       (cfg)
   );

   assign o_hdr_active = cfg.hdr_active;

endmodule

// ==== verification/tb_i3c_bus_monitor.sv ====
module tb_i3c_bus_monitor;

   import i3c_bus_pkg::*;
   import monitor_cfg_pkg::*;

   localparam int EVENT_DEPTH = 8;
   localparam int SCRIPT_BITS = 130;  // Bus bits scripted over all scenarios

   // Bus actions recorded in the log
   localparam int ACT_START    = 0;
   localparam int ACT_STOP     = 1;
   localparam int ACT_BYTE     = 2;
   localparam int ACT_LOW_FALL = 3;

   logic                   i_sys_clk;
   logic                   i_sys_rst;
   logic                   i_scl;
   logic                   i_sda;
   logic                   i_reg_wr;
   logic                   i_reg_rd;
   logic [2:0]             i_reg_addr;
   logic [7:0]             i_reg_wdata;
   logic [7:0]             o_reg_rdata;
   logic                   i_evt_credit;
   logic                   o_evt_valid;
   evt_code_t              o_evt_code;
   logic [STAMP_WIDTH-1:0] o_evt_stamp;
   logic                   o_hdr_active;

   int             bus_log[$];
   evt_code_t      exp_q[$];
   int             filter_depth;
   int             hold_cycles;
   int             cycle_limit;
   int             cycles;
   int             credits_held;
   logic [15:0]    last_stamp;
   bit             stamp_seen;
   logic [7:0]     rd_val;
   int             n_new;

   // Reference model state
   bit             m_enable;
   bit             m_hdr;
   logic [3:0]     m_mask;
   int             m_falls;
   int             m_room;
   int             m_drops;

   i3c_bus_monitor_top #(.EVENT_DEPTH(EVENT_DEPTH)) uut
   (
      .i_sys_clk    (i_sys_clk),
      .i_sys_rst    (i_sys_rst),
      .i_scl        (i_scl),
      .i_sda        (i_sda),
      .i_reg_wr     (i_reg_wr),
      .i_reg_rd     (i_reg_rd),
      .i_reg_addr   (i_reg_addr),
      .i_reg_wdata  (i_reg_wdata),
      .o_reg_rdata  (o_reg_rdata),
      .i_evt_credit (i_evt_credit),
      .o_evt_valid  (o_evt_valid),
      .o_evt_code   (o_evt_code),
      .o_evt_stamp  (o_evt_stamp),
      .o_hdr_active (o_hdr_active)
   );

   initial
   begin
      i_sys_clk = 1'b0;
      forever #20 i_sys_clk = !i_sys_clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // *******************************************************************
   // Reference model
   // *******************************************************************

   function automatic int expect_event(input evt_code_t code);
      if (!m_enable || !m_mask[code])
         return 0;
      if (m_room == 0)
      begin
         m_drops++;  // Full queue refuses it
         return 0;
      end
      m_room--;
      exp_q.push_back(code);
      return 1;
   endfunction

   // Turns the logged bus actions into expected event codes
   function automatic int predict_events();
      int pushed;
      bit armed;
      pushed = 0;
      foreach (bus_log[i])
      begin
         case (bus_log[i])
            ACT_LOW_FALL:
               if (m_enable && m_hdr && m_falls < HDR_EXIT_FALLS)
                  m_falls++;
            ACT_BYTE:
               m_falls = 0;
            default:
            begin
               armed = m_enable && m_hdr && (m_falls == HDR_EXIT_FALLS);
               // An HDR event takes the place of the condition that completed it
               if (armed && bus_log[i] == ACT_STOP)
               begin
                  pushed += expect_event(EVT_HDR_EXIT);
                  m_hdr = 1'b0;
               end
               else if (armed)
                  pushed += expect_event(EVT_HDR_RESTART);
               else if (bus_log[i] == ACT_STOP)
                  pushed += expect_event(EVT_STOP);
               else
                  pushed += expect_event(EVT_START);
               m_falls = 0;
            end
         endcase
      end
      bus_log.delete();
      return pushed;
   endfunction

   // *******************************************************************
   // Bus, register and credit tasks
   // *******************************************************************

   task automatic drive_lines(input logic scl, input logic sda);
      @(posedge i_sys_clk);
      i_scl <= scl;
      i_sda <= sda;
      repeat (hold_cycles - 1) @(posedge i_sys_clk);
   endtask

   task automatic bus_start();
      drive_lines(1'b0, 1'b1);
      drive_lines(1'b1, 1'b1);
      drive_lines(1'b1, 1'b0);
      drive_lines(1'b0, 1'b0);
      bus_log.push_back(ACT_START);
   endtask

   task automatic bus_stop();
      drive_lines(1'b0, 1'b0);
      drive_lines(1'b1, 1'b0);
      drive_lines(1'b1, 1'b1);
      bus_log.push_back(ACT_STOP);
   endtask

   task automatic bus_byte(input logic [7:0] data);
      for (int i = 7; i >= 0; i--)
      begin
         drive_lines(1'b0, data[i]);
         drive_lines(1'b1, data[i]);
         drive_lines(1'b0, data[i]);
      end
      bus_log.push_back(ACT_BYTE);
   endtask

   // SDA falls while SCL stays low
   task automatic low_falls(input int n);
      for (int i = 0; i < n; i++)
      begin
         drive_lines(1'b0, 1'b1);
         drive_lines(1'b0, 1'b0);
         bus_log.push_back(ACT_LOW_FALL);
      end
   endtask

   task automatic sda_glitch(input int len);
      @(posedge i_sys_clk);
      i_sda <= 1'b0;
      repeat (len) @(posedge i_sys_clk);
      i_sda <= 1'b1;
      repeat (hold_cycles) @(posedge i_sys_clk);
   endtask

   task automatic reg_write(input logic [2:0] addr, input logic [7:0] data);
      @(posedge i_sys_clk);
      i_reg_wr    <= 1'b1;
      i_reg_addr  <= addr;
      i_reg_wdata <= data;
      @(posedge i_sys_clk);
      i_reg_wr    <= 1'b0;
      if (addr == REG_CTRL)
      begin
         m_enable = data[CTRL_ENABLE_BIT];
         m_hdr    = data[CTRL_HDR_BIT];
      end
      else if (addr == REG_EVT_MASK)
         m_mask = data[3:0];
   endtask

   task automatic reg_read(input logic [2:0] addr, output logic [7:0] data);
      @(posedge i_sys_clk);
      i_reg_rd   <= 1'b1;
      i_reg_addr <= addr;
      @(posedge i_sys_clk);
      i_reg_rd   <= 1'b0;
      @(posedge i_sys_clk);
      data = o_reg_rdata;
   endtask

   task automatic give_credits(input int n);
      for (int i = 0; i < n; i++)
      begin
         repeat ($urandom % 4) @(posedge i_sys_clk);
         @(posedge i_sys_clk);
         i_evt_credit <= 1'b1;
         credits_held++;
         @(posedge i_sys_clk);
         i_evt_credit <= 1'b0;
      end
   endtask

   // Returns credits for everything predicted, plus spare ones that let an
   // unexpected event out, and waits for the predicted events to arrive
   task automatic drain_events(input int spare);
      n_new = predict_events();
      repeat (20) @(posedge i_sys_clk);
      give_credits(n_new + spare);
      while (exp_q.size() != 0)
         @(posedge i_sys_clk);
      repeat (30) @(posedge i_sys_clk);
   endtask

   // *******************************************************************
   // Compare process and timeout
   // *******************************************************************

   always @(posedge i_sys_clk)
   begin
      if (i_sys_rst && o_evt_valid)
      begin
         if (credits_held <= 0)
            fail_run("an event was sent while no credit was held");
         if (exp_q.size() == 0)
            fail_run("an event arrived that was not expected");
         check_value("o_evt_code", 32'(o_evt_code), 32'(exp_q.pop_front()));
         if (stamp_seen && o_evt_stamp <= last_stamp)
            fail_run("event timestamps did not strictly increase");
         last_stamp = o_evt_stamp;
         stamp_seen = 1'b1;
         credits_held--;
      end
   end

   always @(posedge i_sys_clk)
   begin
      cycles++;
      if (cycles > cycle_limit)
         fail_run("timeout, the run did not finish in time");
   end

   initial
   begin
      void'($urandom(32'hece));
      filter_depth = 1 + ($urandom % 3);  // At least one so short glitches can be filtered
      hold_cycles  = filter_depth + 4;
      cycle_limit  = SCRIPT_BITS * 4 * (filter_depth + 4) + 2000;
      cycles       = 0;
      credits_held = 0;
      stamp_seen   = 1'b0;
      last_stamp   = '0;
      m_enable     = 1'b0;
      m_hdr        = 1'b0;
      m_mask       = '0;
      m_falls      = 0;
      m_room       = 1 << 20;
      m_drops      = 0;
      i_sys_rst    = 1'b0;
      i_scl        = 1'b1;
      i_sda        = 1'b1;
      i_reg_wr     = 1'b0;
      i_reg_rd     = 1'b0;
      i_reg_addr   = '0;
      i_reg_wdata  = '0;
      i_evt_credit = 1'b0;
      repeat (16) @(posedge i_sys_clk);
      i_sys_rst <= 1'b1;

      reg_write(REG_FILTER, 8'(filter_depth));
      reg_write(REG_EVT_MASK, 8'h0f);
      reg_write(REG_CTRL, 8'h01);

      // Plain transfer, valid must stay low until credits come back
      bus_start();
      bus_byte(8'($urandom));
      bus_stop();
      drain_events(0);

      // HDR exit clears the flag
      reg_write(REG_CTRL, 8'h03);
      low_falls(HDR_EXIT_FALLS);
      bus_stop();
      drain_events(0);
      reg_read(REG_CTRL, rd_val);
      check_value("reg_ctrl", rd_val, {6'd0, m_hdr, m_enable});
      check_value("o_hdr_active", o_hdr_active, 1'b0);

      // HDR restart keeps the flag, a short pattern is an ordinary STOP
      reg_write(REG_CTRL, 8'h03);
      low_falls(HDR_EXIT_FALLS);
      bus_start();
      low_falls(HDR_EXIT_FALLS - 1);
      bus_stop();
      drain_events(0);
      reg_read(REG_CTRL, rd_val);
      check_value("reg_ctrl", rd_val, 8'h03);
      reg_write(REG_CTRL, 8'h01);

      // *******************************************************************
      // Queue overflow with credits withheld
      // *******************************************************************
      m_room = EVENT_DEPTH;
      for (int i = 0; i < 12; i++)
      begin
         bus_start();
         bus_stop();
      end
      drain_events(0);
      m_room = 1 << 20;
      reg_read(REG_DROP_CNT, rd_val);
      check_value("reg_drop_cnt", rd_val, 8'(m_drops));
      reg_write(REG_DROP_CNT, 8'h00);
      reg_read(REG_DROP_CNT, rd_val);
      check_value("reg_drop_cnt", rd_val, 8'h00);

      reg_write(REG_EVT_MASK, 8'h0e);
      for (int i = 0; i < 2; i++)
      begin
         bus_start();
         bus_stop();
      end
      drain_events(0);

      // Short SDA pulses under a high SCL, a spare credit lets any false event out
      reg_write(REG_EVT_MASK, 8'h0f);
      for (int i = 0; i < 3; i++)
         sda_glitch(1 + ($urandom % filter_depth));
      drain_events(1);

      reg_write(REG_CTRL, 8'h00);
      for (int i = 0; i < 2; i++)
      begin
         bus_start();
         bus_stop();
      end
      drain_events(1);

      if (exp_q.size() != 0)
         fail_run("expected events never arrived");
      else
      begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== files.f ====
hdl/i3c_bus_pkg.sv
hdl/monitor_cfg_pkg.sv
hdl/bus_line_if.sv
hdl/bus_sampler.sv
hdl/bus_condition_detector.sv
hdl/hdr_exit_detector.sv
hdl/event_credit_tx.sv
hdl/monitor_regs.sv
hdl/i3c_bus_monitor_top.sv
verification/tb_i3c_bus_monitor.sv
